// File: hw/udp_loop_defines.svh
`ifndef UDP_LOOP_DEFINES_SVH
`define UDP_LOOP_DEFINES_SVH

// stream widths
`define UDP_WIDE_W     64
`define UDP_NARROW_W   32

// payload beats per packet, 1 to 15
`define UDP_BEATS_W    4

// fixed udp ports
`define UDP_SRC_PORT   16'h1234
`define UDP_DST_PORT   16'h5678

`define UDP_HDR_BYTES  8   // one wide beat of header
`define UDP_CNT_W      16  // status counter width

`endif

// File: hw/eth_frame_pkg.sv
`default_nettype none

package eth_frame_pkg;

  // field order follows the udp header on the wire, src_port in the top bits
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;    // header plus payload, in bytes
    logic [15:0] checksum;  // zero means not used
  } udp_hdr_t;

  // one wide word seen as header fields or as a plain data word
  typedef union packed {
    udp_hdr_t    f;
    logic [63:0] raw;
  } udp_hdr_u;

endpackage

`default_nettype wire

// File: hw/axis_pkg.sv
`default_nettype none
`include "udp_loop_defines.svh"

package axis_pkg;

  // last sits in bit 0, data above it
  typedef struct packed {
    logic [`UDP_WIDE_W-1:0]   data;
    logic                     last;
  } wide_beat_t;

  typedef struct packed {
    logic [`UDP_NARROW_W-1:0] data;
    logic                     last;
  } narrow_beat_t;

endpackage

`default_nettype wire

// File: hw/pkt_gen.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_loop_defines.svh"

module pkt_gen (
  input  wire                      pkt_clk,
  input  wire                      rst_n,
  input  wire                      gen_en,
  input  wire [`UDP_BEATS_W-1:0]   payload_beats,
  output axis_pkg::wide_beat_t     out_beat,
  output logic                     out_valid,
  input  wire                      out_ready
);

  logic                    active_q;  // packet in progress
  logic [`UDP_BEATS_W-1:0] beats_q;   // payload length of current packet
  logic [`UDP_BEATS_W-1:0] idx_q;     // next payload beat number
  logic [15:0]             seq_q;
  logic [31:0]             word_hi;
  logic                    is_last;
  logic                    load;

  assign word_hi = {seq_q, 16'(idx_q)};           // seq on top, beat number below
  assign is_last = (idx_q == beats_q - 1'b1);
  assign load    = active_q && (!out_valid || out_ready);

  always_ff @(posedge pkt_clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q  <= 1'b0;
      beats_q   <= '0;
      idx_q     <= '0;
      seq_q     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (load) begin
        out_valid <= 1'b1;
        idx_q     <= idx_q + 1'b1;
        if (is_last) begin
          active_q <= 1'b0;
          seq_q    <= seq_q + 1'b1;  // wraps at 2^16
        end
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
      // may start while the previous last beat still waits
      if (!active_q && gen_en) begin
        active_q <= 1'b1;
        beats_q  <= payload_beats;
        idx_q    <= '0;
      end
    end
  end

  always_ff @(posedge pkt_clk) begin
    if (load) begin
      out_beat.data <= {word_hi, ~word_hi};  // low word is the inverse
      out_beat.last <= is_last;
    end
  end

endmodule

`default_nettype wire

// File: hw/udp_tx_framer.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_loop_defines.svh"

module udp_tx_framer (
  input  wire                      pkt_clk,
  input  wire                      rst_n,
  input  wire [`UDP_BEATS_W-1:0]   payload_beats,
  input  wire axis_pkg::wide_beat_t in_beat,
  input  wire                      in_valid,
  output logic                     in_ready,
  output axis_pkg::wide_beat_t     out_beat,
  output logic                     out_valid,
  input  wire                      out_ready
);

  import eth_frame_pkg::*;

  typedef enum logic {
    ST_HDR,
    ST_PAY
  } state_t;

  state_t   state_q;
  udp_hdr_u hdr;
  logic     can_load;
  logic     hdr_load;
  logic     pay_load;

  // payload_beats has to hold until the header beat is loaded
  always_comb begin
    hdr.f.src_port = `UDP_SRC_PORT;
    hdr.f.dst_port = `UDP_DST_PORT;
    hdr.f.length   = 16'(`UDP_HDR_BYTES * (payload_beats + 1));
    hdr.f.checksum = 16'h0000;
  end

  assign can_load = !out_valid || out_ready;
  assign in_ready = (state_q == ST_PAY) && can_load;  // payload held back during header
  assign hdr_load = (state_q == ST_HDR) && in_valid && can_load;
  assign pay_load = in_valid && in_ready;

  always_ff @(posedge pkt_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= ST_HDR;
      out_valid <= 1'b0;
    end else begin
      if (hdr_load) begin
        out_valid <= 1'b1;
        state_q   <= ST_PAY;
      end else if (pay_load) begin
        out_valid <= 1'b1;
        if (in_beat.last)
          state_q <= ST_HDR;  // next packet gets its own header
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge pkt_clk) begin
    if (hdr_load) begin
      out_beat.data <= hdr.raw;
      out_beat.last <= 1'b0;
    end else if (pay_load) begin
      out_beat <= in_beat;
    end
  end

endmodule

`default_nettype wire

// File: hw/axis_downsizer.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_loop_defines.svh"

module axis_downsizer (
  input  wire                        pkt_clk,
  input  wire                        rst_n,
  input  wire axis_pkg::wide_beat_t  in_beat,
  input  wire                        in_valid,
  output logic                       in_ready,
  output axis_pkg::narrow_beat_t     out_beat,
  output logic                       out_valid,
  input  wire                        out_ready
);

  import axis_pkg::*;

  wide_beat_t hold_q;
  logic       full_q;
  logic       half_q;  // 0 lower half, 1 upper half

  // refill as the upper half leaves
  assign in_ready  = !full_q || (out_ready && half_q);
  assign out_valid = full_q;

  always_comb begin
    out_beat.data = half_q ? hold_q.data[`UDP_WIDE_W-1:`UDP_NARROW_W]
                           : hold_q.data[`UDP_NARROW_W-1:0];
    out_beat.last = half_q && hold_q.last;  // last rides on the upper half only
  end

  always_ff @(posedge pkt_clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
      half_q <= 1'b0;
    end else if (in_valid && in_ready) begin
      full_q <= 1'b1;
      half_q <= 1'b0;
    end else if (out_valid && out_ready) begin
      half_q <= ~half_q;
      if (half_q)
        full_q <= 1'b0;
    end
  end

  always_ff @(posedge pkt_clk) begin
    if (in_valid && in_ready)
      hold_q <= in_beat;
  end

endmodule

`default_nettype wire

// File: hw/axis_upsizer.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_loop_defines.svh"

module axis_upsizer (
  input  wire                          pkt_clk,
  input  wire                          rst_n,
  input  wire axis_pkg::narrow_beat_t  in_beat,
  input  wire                          in_valid,
  output logic                         in_ready,
  output axis_pkg::wide_beat_t         out_beat,
  output logic                         out_valid
);

  logic [`UDP_NARROW_W-1:0] lo_q;       // first half waiting for its partner
  logic                     have_lo_q;
  logic                     sink_ready;
  logic                     take;

  // checker downstream never stalls
  assign sink_ready = 1'b1;
  assign in_ready   = !out_valid || sink_ready;
  assign take       = in_valid && in_ready;

  always_ff @(posedge pkt_clk or negedge rst_n) begin
    if (!rst_n) begin
      have_lo_q <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (out_valid && sink_ready)
        out_valid <= 1'b0;  // joined beat shown one cycle
      if (take) begin
        if (have_lo_q) begin
          have_lo_q <= 1'b0;
          out_valid <= 1'b1;
        end else begin
          have_lo_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge pkt_clk) begin
    if (take && !have_lo_q)
      lo_q <= in_beat.data;
    if (take && have_lo_q) begin
      out_beat.data <= {in_beat.data, lo_q};
      out_beat.last <= in_beat.last;  // last of the first half is ignored
    end
  end

endmodule

`default_nettype wire

// File: hw/udp_rx_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_loop_defines.svh"

module udp_rx_checker (
  input  wire                        pkt_clk,
  input  wire                        rst_n,
  input  wire axis_pkg::wide_beat_t  in_beat,
  input  wire                        in_valid,
  output logic [`UDP_CNT_W-1:0]      pkt_count,
  output logic [`UDP_CNT_W-1:0]      err_count,
  output logic                       err_flag
);

  import eth_frame_pkg::*;

  udp_hdr_u    hdr;
  logic        at_hdr_q;    // next beat is a header
  logic [15:0] idx_q;       // payload beat number
  logic [15:0] len_q;       // length field of current packet
  logic        bad_q;       // packet bad so far
  logic        done_q;
  logic        done_bad_q;
  logic [31:0] exp_hi;
  logic [15:0] len_now;
  logic [15:0] rx_bytes;
  logic        hdr_bad;
  logic        word_bad;
  logic        len_bad;
  logic        pkt_bad;

  always_comb begin
    hdr.raw  = in_beat.data;
    hdr_bad  = (hdr.f.src_port != `UDP_SRC_PORT) || (hdr.f.dst_port != `UDP_DST_PORT) ||
               (hdr.f.checksum != 16'h0000);
    exp_hi   = {pkt_count[15:0], idx_q};  // sequence must equal pkt_count
    word_bad = (in_beat.data != {exp_hi, ~exp_hi});
    len_now  = at_hdr_q ? hdr.f.length : len_q;
    rx_bytes = at_hdr_q ? 16'(`UDP_HDR_BYTES) : 16'(`UDP_HDR_BYTES * (idx_q + 2));
    len_bad  = (len_now != rx_bytes);
    pkt_bad  = (at_hdr_q ? hdr_bad : (bad_q || word_bad)) || len_bad;
  end

  always_ff @(posedge pkt_clk or negedge rst_n) begin
    if (!rst_n) begin
      at_hdr_q   <= 1'b1;
      idx_q      <= '0;
      len_q      <= '0;
      bad_q      <= 1'b0;
      done_q     <= 1'b0;
      done_bad_q <= 1'b0;
      pkt_count  <= '0;
      err_count  <= '0;
      err_flag   <= 1'b0;
    end else begin
      done_q     <= in_valid && in_beat.last;
      done_bad_q <= pkt_bad;
      if (in_valid) begin
        at_hdr_q <= in_beat.last;
        if (at_hdr_q) begin
          len_q <= hdr.f.length;
          bad_q <= hdr_bad;
          idx_q <= '0;
        end else begin
          bad_q <= bad_q || word_bad;
          idx_q <= idx_q + 1'b1;
        end
      end
      // counters follow one edge after the last beat
      if (done_q) begin
        pkt_count <= pkt_count + 1'b1;
        if (done_bad_q) begin
          err_count <= err_count + 1'b1;
          err_flag  <= 1'b1;  // sticky
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/udp_loop_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_loop_defines.svh"

module udp_loop_top (
  input  wire                          pkt_clk,
  input  wire                          rst_n,
  input  wire                          gen_en,
  input  wire [`UDP_BEATS_W-1:0]       payload_beats,
  output axis_pkg::narrow_beat_t       tx_beat,
  output logic                         tx_valid,
  input  wire                          tx_ready,
  input  wire axis_pkg::narrow_beat_t  rx_beat,
  input  wire                          rx_valid,
  output logic                         rx_ready,
  output logic [`UDP_CNT_W-1:0]        pkt_count,
  output logic [`UDP_CNT_W-1:0]        err_count,
  output logic                         err_flag
);

  import axis_pkg::*;

  wide_beat_t gen_beat;  // generator to framer
  logic       gen_valid;
  logic       gen_ready;
  wide_beat_t frm_beat;  // framer to downsizer
  logic       frm_valid;
  logic       frm_ready;
  wide_beat_t ups_beat;  // upsizer to checker
  logic       ups_valid;

  pkt_gen u_pkt_gen (
    .pkt_clk       (pkt_clk),
    .rst_n         (rst_n),
    .gen_en        (gen_en),
    .payload_beats (payload_beats),
    .out_beat      (gen_beat),
    .out_valid     (gen_valid),
    .out_ready     (gen_ready)
  );

  udp_tx_framer u_udp_tx_framer (
    .pkt_clk       (pkt_clk),
    .rst_n         (rst_n),
    .payload_beats (payload_beats),
    .in_beat       (gen_beat),
    .in_valid      (gen_valid),
    .in_ready      (gen_ready),
    .out_beat      (frm_beat),
    .out_valid     (frm_valid),
    .out_ready     (frm_ready)
  );

  axis_downsizer u_axis_downsizer (
    .pkt_clk   (pkt_clk),
    .rst_n     (rst_n),
    .in_beat   (frm_beat),
    .in_valid  (frm_valid),
    .in_ready  (frm_ready),
    .out_beat  (tx_beat),
    .out_valid (tx_valid),
    .out_ready (tx_ready)
  );

  axis_upsizer u_axis_upsizer (
    .pkt_clk   (pkt_clk),
    .rst_n     (rst_n),
    .in_beat   (rx_beat),
    .in_valid  (rx_valid),
    .in_ready  (rx_ready),
    .out_beat  (ups_beat),
    .out_valid (ups_valid)
  );

  udp_rx_checker u_udp_rx_checker (
    .pkt_clk   (pkt_clk),
    .rst_n     (rst_n),
    .in_beat   (ups_beat),
    .in_valid  (ups_valid),
    .pkt_count (pkt_count),
    .err_count (err_count),
    .err_flag  (err_flag)
  );

endmodule

`default_nettype wire

// File: dv/udp_loop_chk.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_loop_defines.svh"

module udp_loop_chk (
  input  wire                          pkt_clk,
  input  wire                          rst_n,
  input  wire                          gen_en,
  input  wire [`UDP_BEATS_W-1:0]       payload_beats,
  input  wire axis_pkg::narrow_beat_t  tx_beat,
  input  wire                          tx_valid,
  input  wire                          tx_ready,
  input  wire [`UDP_CNT_W-1:0]         pkt_count,
  input  wire [`UDP_CNT_W-1:0]         err_count
);

  // a stalled beat waits unchanged on the link
  a_tx_hold: assert property (@(posedge pkt_clk) disable iff (!rst_n)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
    else $error("tx beat changed while tx_ready was low");

  a_err_le_pkt: assert property (@(posedge pkt_clk) disable iff (!rst_n)
    err_count <= pkt_count)
    else $error("err_count is above pkt_count");

  a_beats_nonzero: assert property (@(posedge pkt_clk) disable iff (!rst_n)
    gen_en |-> payload_beats != '0)
    else $error("gen_en high with a payload length of zero");

endmodule

`default_nettype wire

// File: dv/udp_loop_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_loop_defines.svh"

module udp_loop_tb;

  import axis_pkg::*;

  localparam int BEATS_W        = `UDP_BEATS_W;
  localparam int CLEAN_PKTS     = 40;
  localparam int BP_PKTS        = 30;
  localparam int CORR_PKTS      = 4;  // per corruption test, one of them bad
  localparam int RST_PKTS       = 4;
  localparam int TOTAL_PKTS     = CLEAN_PKTS + BP_PKTS + 3 * CORR_PKTS + RST_PKTS;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_PKTS + 2000;
  localparam int CORR_NONE      = 0;
  localparam int CORR_PAY       = 1;
  localparam int CORR_HDR       = 2;
  localparam int CORR_TRUNC     = 3;

  logic                  pkt_clk;
  logic                  rst_n;
  logic                  gen_en;
  logic [BEATS_W-1:0]    payload_beats;
  narrow_beat_t          tx_beat;
  logic                  tx_valid;
  logic                  tx_ready;
  narrow_beat_t          rx_beat;
  logic                  rx_valid;
  logic                  rx_ready;
  logic [`UDP_CNT_W-1:0] pkt_count;
  logic [`UDP_CNT_W-1:0] err_count;
  logic                  err_flag;

  narrow_beat_t          exp_q[$];   // tx beats still expected
  narrow_beat_t          link_q[$];  // beats on the cable
  logic [31:0]           rng_state;
  logic [15:0]           seq_model;
  logic [`UDP_CNT_W-1:0] exp_pkts;
  logic [`UDP_CNT_W-1:0] exp_errs;
  int                    tx_idx;     // narrow beat number in the packet on tx
  int                    tx_total;
  int                    corr_kind;
  int                    corr_beat;
  int                    corr_bit;
  bit                    stall_en;   // random tx_ready stalls and rx gaps
  string                 test_name;
  int                    tests;
  int                    checks;
  int                    errors;
  int                    test_errors;

  udp_loop_top i_udp_loop_top (
    .pkt_clk       (pkt_clk),
    .rst_n         (rst_n),
    .gen_en        (gen_en),
    .payload_beats (payload_beats),
    .tx_beat       (tx_beat),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready),
    .rx_beat       (rx_beat),
    .rx_valid      (rx_valid),
    .rx_ready      (rx_ready),
    .pkt_count     (pkt_count),
    .err_count     (err_count),
    .err_flag      (err_flag)
  );

  bind udp_loop_top udp_loop_chk i_udp_loop_chk (
    .pkt_clk       (pkt_clk),
    .rst_n         (rst_n),
    .gen_en        (gen_en),
    .payload_beats (payload_beats),
    .tx_beat       (tx_beat),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready),
    .pkt_count     (pkt_count),
    .err_count     (err_count)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_below(input int n);
    rng_state = xorshift(rng_state);
    return int'(rng_state % 32'(n));
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("ERR %s %s: expected %h actual %h", test_name, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  // one clock: sample at the falling edge, drive 1 ns after the rising edge
  task automatic tick();
    narrow_beat_t exp_b;
    narrow_beat_t b;
    logic         rx_taken;
    @(negedge pkt_clk);
    rx_taken = rx_valid && rx_ready;
    if (rx_taken)
      b = link_q.pop_front();
    if (tx_valid && tx_ready) begin
      if (exp_q.size() == 0) begin
        $display("%s: tx beat %h sent while no beat was expected", test_name, tx_beat);
        errors++;
        test_errors++;
      end else begin
        exp_b = exp_q.pop_front();
        check_value("tx beat", 64'(exp_b), 64'(tx_beat));
      end
      b = tx_beat;
      if (corr_kind == CORR_PAY && tx_idx == corr_beat)
        b.data[corr_bit] = ~b.data[corr_bit];
      if (corr_kind == CORR_HDR && tx_idx == 1)
        b.data[0] = ~b.data[0];  // dst port, low bits of upper header half
      if (corr_kind == CORR_TRUNC && tx_idx == tx_total - 3)
        b.last = 1'b1;
      if (!(corr_kind == CORR_TRUNC && tx_idx >= tx_total - 2))
        link_q.push_back(b);
      tx_idx++;
    end
    @(posedge pkt_clk);
    #1;
    tx_ready = stall_en ? (rand_below(4) != 0) : 1'b1;
    if (!(rx_valid && !rx_taken)) begin
      if (link_q.size() != 0 && !(stall_en && rand_below(4) == 0)) begin
        rx_beat  = link_q[0];
        rx_valid = 1'b1;
      end else begin
        rx_valid = 1'b0;
      end
    end
  endtask

  task automatic start_packet(input int n, input int kind);
    logic [31:0]  hi;
    narrow_beat_t b;
    int           k;
    b.last = 1'b0;
    b.data = {16'(`UDP_HDR_BYTES * (n + 1)), 16'h0000};  // length and checksum first
    exp_q.push_back(b);
    b.data = {`UDP_SRC_PORT, `UDP_DST_PORT};
    exp_q.push_back(b);
    for (k = 0; k < n; k++) begin
      hi     = {seq_model, 16'(k)};
      b.data = ~hi;
      b.last = 1'b0;
      exp_q.push_back(b);
      b.data = hi;
      b.last = (k == n - 1);
      exp_q.push_back(b);
    end
    tx_idx    = 0;
    tx_total  = 2 * (n + 1);
    corr_kind = kind;
    corr_beat = 2 + rand_below(2 * n);
    corr_bit  = rand_below(32);
    seq_model = seq_model + 16'd1;
    exp_pkts  = exp_pkts + 1'b1;
    if (kind != CORR_NONE)
      exp_errs = exp_errs + 1'b1;
    payload_beats = BEATS_W'(n);
    gen_en        = 1'b1;
    tick();
    gen_en = 1'b0;
  endtask

  task automatic send_packet(input int n, input int kind);
    start_packet(n, kind);
    while (tx_idx < tx_total)
      tick();
    corr_kind = CORR_NONE;
  endtask

  task automatic drain();
    while (link_q.size() != 0 || rx_valid || pkt_count != exp_pkts)
      tick();
  endtask

  task automatic apply_reset();
    rst_n    = 1'b0;
    gen_en   = 1'b0;
    rx_valid = 1'b0;
    exp_q.delete();
    link_q.delete();
    seq_model = '0;
    exp_pkts  = '0;
    exp_errs  = '0;
    tx_idx    = 0;
    tx_total  = 0;
    corr_kind = CORR_NONE;
    repeat (8) tick();
    rst_n = 1'b1;
  endtask

  task automatic check_counts();
    check_value("pkt_count", 64'(exp_pkts), 64'(pkt_count));
    check_value("err_count", 64'(exp_errs), 64'(err_count));
    check_value("err_flag", 64'(exp_errs != 0), 64'(err_flag));
  endtask

  task automatic check_idle();
    check_value("tx_valid", 64'd0, 64'(tx_valid));
    check_value("rx_ready", 64'd1, 64'(rx_ready));
  endtask

  task automatic finish_test();
    tests++;
    $display("test %s done, %0d errors", test_name, test_errors);
    test_errors = 0;
  endtask

  task automatic run_corrupt(input string name, input int kind);
    int i;
    test_name = name;
    for (i = 0; i < CORR_PKTS; i++)
      send_packet(1 + rand_below(15), (i == 1) ? kind : CORR_NONE);
    drain();
    check_counts();
    finish_test();
  endtask

  initial begin
    pkt_clk = 1'b0;
    forever #4 pkt_clk = ~pkt_clk;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge pkt_clk);
      cycles++;
    end
    $display("timeout: the run was still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial begin : main_seq
    int i;
    rst_n         = 1'b0;
    gen_en        = 1'b0;
    payload_beats = BEATS_W'(1);
    tx_ready      = 1'b1;
    rx_beat       = '0;
    rx_valid      = 1'b0;
    rng_state     = 32'd85444;
    stall_en      = 1'b0;
    tests         = 0;
    checks        = 0;
    errors        = 0;
    test_errors   = 0;

    test_name = "power_on_reset";
    apply_reset();
    check_idle();
    check_counts();
    finish_test();

    test_name = "clean_loop";
    for (i = 0; i < CLEAN_PKTS; i++)
      send_packet(1 + rand_below(15), CORR_NONE);
    drain();
    check_counts();
    finish_test();

    test_name = "back_pressure";
    stall_en  = 1'b1;
    for (i = 0; i < BP_PKTS; i++)
      send_packet(1 + rand_below(15), CORR_NONE);
    drain();
    check_counts();
    finish_test();

    run_corrupt("payload_corrupt", CORR_PAY);
    run_corrupt("header_corrupt", CORR_HDR);
    run_corrupt("truncated_packet", CORR_TRUNC);

    // reset lands while a packet is on its way
    test_name = "mid_run_reset";
    start_packet(10, CORR_NONE);
    repeat (6) tick();
    apply_reset();
    check_idle();
    check_counts();
    for (i = 0; i < RST_PKTS - 1; i++)
      send_packet(1 + rand_below(15), CORR_NONE);
    drain();
    check_counts();
    finish_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: udp_loop_top.f
+incdir+hw
hw/eth_frame_pkg.sv
hw/axis_pkg.sv
hw/pkt_gen.sv
hw/udp_tx_framer.sv
hw/axis_downsizer.sv
hw/axis_upsizer.sv
hw/udp_rx_checker.sv
hw/udp_loop_top.sv
dv/udp_loop_chk.sv
dv/udp_loop_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module udp_loop_tb -f udp_loop_top.f

./obj_dir/Vudp_loop_tb 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
